//--- design/asicCfgPkg.sv
/*
  Shared constants and the payload word for the tracker ASIC configuration chain.
  All frames share one layout: start pair, address, opcode, parity, payload, trailer.
  Parity is even over address, opcode, parity and payload.
  The payload word is always 64 bits wide; narrower payloads sit in its low bits.
*/
`default_nettype none

package asicCfgPkg;

  // Command opcodes as seen by the ASICs
  localparam logic [3:0] OpConfig   = 4'b1011;
  localparam logic [3:0] OpThrDac   = 4'b1010;
  localparam logic [3:0] OpDataMask = 4'b1100;
  localparam logic [3:0] OpTrigMask = 4'b1101;

  localparam logic [3:0] BroadcastAddr = 4'hF;  // All chips listen

  // Frame framing bits
  localparam logic [1:0] StartBits = 2'b10;  // Sent first, one then zero
  localparam logic [1:0] TrailBits = 2'b00;

  // Payload widths
  localparam int CfgBits  = 19;
  localparam int DacBits  = 8;
  localparam int MaskBits = 64;

  // Start pair, address, opcode, parity and trailer together
  localparam int FrameOverhead = 2 + 4 + 4 + 1 + 2;

  localparam int CfgFrameBits  = FrameOverhead + CfgBits;   // 32
  localparam int DacFrameBits  = FrameOverhead + DacBits;   // 21
  localparam int FrameMaxBits  = FrameOverhead + MaskBits;  // 77, mask frames

  // One payload word, read as mask, threshold or configuration register
  typedef union packed {
    logic [MaskBits-1:0] mask;      // Channel mask, bit 63 first on the line
    struct packed {
      logic [MaskBits-DacBits-1:0] unused;
      logic [DacBits-1:0]          thr;   // Threshold DAC code
    } dac;
    struct packed {
      logic [MaskBits-CfgBits-1:0] unused;
      logic [CfgBits-1:0]          word;  // Configuration register
    } cfg;
  } settingPayloadT;

endpackage

`default_nettype wire

//--- design/cfgSequencer.sv
/*
  Walks the power-up command list: one broadcast configure, then threshold DAC,
  data mask and trigger mask commands for chips 0 to NumChips-1.
  Go is only looked at while idle. Done is a one-cycle pulse.
  NumChips must be 1 to 15, GapCycles at least 1.
  opcode and chipAddr stay stable while a req/ack handshake is open.
*/
`default_nettype none
`timescale 1ns/100ps

module cfgSequencer #(
  parameter int NumChips  = 12,
  parameter int GapCycles = 16
) (
  input  logic       Clock,
  input  logic       arstN,
  input  logic       Go,       // One-cycle start pulse
  input  logic       cmdAck,
  output logic       cmdReq,
  output logic [3:0] opcode,
  output logic [3:0] chipAddr,
  output logic       Done
);

  import asicCfgPkg::*;

  // FSM states
  localparam logic [2:0] SIdle       = 3'd0;
  localparam logic [2:0] SGap        = 3'd1;
  localparam logic [2:0] SReq        = 3'd2;
  localparam logic [2:0] SWaitAckLow = 3'd3;
  localparam logic [2:0] SDone       = 3'd4;

  // Command phases, in transmission order
  localparam logic [1:0] PhConfig   = 2'd0;
  localparam logic [1:0] PhDac      = 2'd1;
  localparam logic [1:0] PhDataMask = 2'd2;
  localparam logic [1:0] PhTrigMask = 2'd3;

  localparam int         GapW     = $clog2(GapCycles + 1);
  localparam logic [GapW-1:0] GapLast = GapW'(GapCycles - 1);
  localparam logic [3:0] LastChip = 4'(NumChips - 1);

  logic [2:0]      state;
  logic [1:0]      phase;
  logic [3:0]      chipCnt;
  logic [GapW-1:0] gapCnt;
  logic            lastInPhase;
  logic            lastFrame;

  // Configure is a single broadcast frame
  assign lastInPhase = (phase == PhConfig) || (chipCnt == LastChip);
  assign lastFrame   = (phase == PhTrigMask) && lastInPhase;

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      state   <= SIdle;
      phase   <= PhConfig;
      chipCnt <= '0;
      gapCnt  <= '0;
    end else begin
      case (state)
        SIdle: begin
          if (Go) begin
            phase   <= PhConfig;
            chipCnt <= '0;
            state   <= SReq;            // No gap before the first frame
          end
        end
        SGap: begin
          if (gapCnt == GapLast) state <= SReq;
          else gapCnt <= gapCnt + 1'b1;
        end
        SReq: begin
          if (cmdAck) state <= SWaitAckLow;  // Frame is out, drop req
        end
        SWaitAckLow: begin
          if (!cmdAck) begin
            if (lastFrame) begin
              state <= SDone;
            end else begin
              gapCnt <= '0;
              state  <= SGap;
              if (lastInPhase) begin      // On to the next command type
                phase   <= phase + 1'b1;
                chipCnt <= '0;
              end else begin
                chipCnt <= chipCnt + 1'b1;
              end
            end
          end
        end
        SDone:   state <= SIdle;
        default: state <= SIdle;
      endcase
    end
  end

  assign cmdReq = (state == SReq);
  assign Done   = (state == SDone);

  // Command selection shared by the table and the serializer
  always_comb begin
    case (phase)
      PhConfig:   opcode = OpConfig;
      PhDac:      opcode = OpThrDac;
      PhDataMask: opcode = OpDataMask;
      default:    opcode = OpTrigMask;
    endcase
  end

  assign chipAddr = (phase == PhConfig) ? BroadcastAddr : chipCnt;

endmodule

`default_nettype wire

//--- design/cfgSettingsTable.sv
/*
  Board default settings for the twelve front-end ASICs, zero latency.
  Only one board's values are held; chips 12 to 14 have no entry and read all ones.
  Addresses at or beyond NumChips also read all ones, as does an unknown opcode.
  Payload bits above the selected view are zero for configure and DAC.
*/
`default_nettype none
`timescale 1ns/100ps

module cfgSettingsTable #(
  parameter int NumChips = 12
) (
  input  logic [3:0]                opcode,
  input  logic [3:0]                chipAddr,
  output asicCfgPkg::settingPayloadT payload
);

  import asicCfgPkg::*;

  localparam logic [4:0] NumChipsW = 5'(NumChips);

  // Same configuration register on every chip
  localparam logic [CfgBits-1:0] CfgWord = 19'b1010111001000111000;

  // Thresholds tuned per chip for signal to noise
  localparam logic [DacBits-1:0] ThrDac [16] = '{
    8'd22, 8'd22, 8'd21, 8'd20,
    8'd22, 8'd24, 8'd20, 8'd24,
    8'd21, 8'd23, 8'd23, 8'd22,
    8'hFF, 8'hFF, 8'hFF, 8'hFF   // No chip fitted
  };

  // First and last channel of the board kept out of the trigger, they are noisy
  localparam logic [MaskBits-1:0] TrigMask [16] = '{
    0:       64'hFFFF_FFFF_FFFF_FFFE,
    11:      64'h7FFF_FFFF_FFFF_FFFF,
    default: '1
  };

  logic chipValid;

  assign chipValid = ({1'b0, chipAddr} < NumChipsW);

  always_comb begin
    payload = '1;   // Unknown opcode or chip
    case (opcode)
      OpConfig: begin                 // Broadcast, address not checked
        payload          = '0;
        payload.cfg.word = CfgWord;
      end
      OpThrDac: begin
        if (chipValid) begin
          payload         = '0;
          payload.dac.thr = ThrDac[chipAddr];
        end
      end
      OpDataMask: ;                   // All ones enables every channel for data
      OpTrigMask: if (chipValid) payload.mask = TrigMask[chipAddr];
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/frameSerializer.sv
/*
  Turns one command into a serial frame on CMD, most significant bit first.
  Takes the command on the first cycle cmdReq is high while idle; first bit
  appears the next cycle, cmdAck rises the cycle after the last bit.
  cmdAck stays high until cmdReq drops. CMD is low outside a frame.
  Any opcode other than configure or DAC is sent as a 64-bit mask frame.
*/
`default_nettype none
`timescale 1ns/100ps

module frameSerializer (
  input  logic                      Clock,
  input  logic                      arstN,
  input  logic                      cmdReq,
  input  logic [3:0]                opcode,
  input  logic [3:0]                chipAddr,
  input  asicCfgPkg::settingPayloadT payload,
  output logic                      cmdAck,
  output logic                      CMD       // Serial command line to the ASICs
);

  import asicCfgPkg::*;

  localparam int CntW = $clog2(FrameMaxBits + 1);

  // FSM states
  localparam logic [1:0] SIdle  = 2'd0;
  localparam logic [1:0] SShift = 2'd1;
  localparam logic [1:0] SAck   = 2'd2;

  logic [1:0]              state;
  logic [CntW-1:0]         bitCnt;     // Bits still to send after the one on CMD
  logic [CntW-1:0]         frameLen;
  logic                    parity;
  logic [FrameMaxBits-1:0] frameWord;  // Left-aligned frame being built
  logic [FrameMaxBits-1:0] shiftReg;
  logic                    capture;

  assign capture = (state == SIdle) && cmdReq;

  // Frame assembly, parity over the selected payload view only
  always_comb begin
    case (opcode)
      OpConfig: begin
        parity    = ^{chipAddr, opcode, payload.cfg.word};
        frameLen  = CntW'(CfgFrameBits);
        frameWord = {StartBits, chipAddr, opcode, parity, payload.cfg.word, TrailBits,
                     {(FrameMaxBits - CfgFrameBits){1'b0}}};
      end
      OpThrDac: begin
        parity    = ^{chipAddr, opcode, payload.dac.thr};
        frameLen  = CntW'(DacFrameBits);
        frameWord = {StartBits, chipAddr, opcode, parity, payload.dac.thr, TrailBits,
                     {(FrameMaxBits - DacFrameBits){1'b0}}};
      end
      default: begin                   // Data and trigger mask
        parity    = ^{chipAddr, opcode, payload.mask};
        frameLen  = CntW'(FrameMaxBits);
        frameWord = {StartBits, chipAddr, opcode, parity, payload.mask, TrailBits};
      end
    endcase
  end

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      state  <= SIdle;
      bitCnt <= '0;
      CMD    <= 1'b0;
    end else begin
      case (state)
        SIdle: begin
          if (cmdReq) begin
            CMD    <= frameWord[FrameMaxBits-1];  // Start bit goes out right away
            bitCnt <= frameLen - 1'b1;
            state  <= SShift;
          end
        end
        SShift: begin
          if (bitCnt == '0) begin
            CMD   <= 1'b0;
            state <= SAck;
          end else begin
            CMD    <= shiftReg[FrameMaxBits-1];
            bitCnt <= bitCnt - 1'b1;
          end
        end
        SAck: begin
          if (!cmdReq) state <= SIdle;  // Second half of the handshake
        end
        default: state <= SIdle;
      endcase
    end
  end

  // Frame data, MSB already sent on capture
  always_ff @(posedge Clock) begin
    if (capture) shiftReg <= {frameWord[FrameMaxBits-2:0], 1'b0};
    else if (state == SShift) shiftReg <= {shiftReg[FrameMaxBits-2:0], 1'b0};
  end

  assign cmdAck = (state == SAck);

endmodule

`default_nettype wire

//--- design/asicCfgTop.sv
/*
  Power-up configuration sequencer for a twelve-ASIC tracker board.
  A Go pulse while idle sends the whole command list on CMD; Done pulses at the end.
  Go during a run is ignored. NumChips 1 to 15, GapCycles at least 1.
  CMD stays low for at least GapCycles cycles between frames.
*/
`default_nettype none
`timescale 1ns/100ps

module asicCfgTop #(
  parameter int NumChips  = 12,
  parameter int GapCycles = 16
) (
  input  logic Clock,
  input  logic arstN,
  input  logic Go,
  output logic CMD,
  output logic Done
);

  import asicCfgPkg::*;

  logic           cmdReq;
  logic           cmdAck;
  logic [3:0]     opcode;
  logic [3:0]     chipAddr;
  settingPayloadT payload;

  cfgSequencer #(
    .NumChips  (NumChips),
    .GapCycles (GapCycles)
  ) uSequencer (
    .Clock    (Clock),
    .arstN    (arstN),
    .Go       (Go),
    .cmdAck   (cmdAck),
    .cmdReq   (cmdReq),
    .opcode   (opcode),
    .chipAddr (chipAddr),
    .Done     (Done)
  );

  // Looks up the same command the sequencer is offering
  cfgSettingsTable #(
    .NumChips (NumChips)
  ) uSettings (
    .opcode   (opcode),
    .chipAddr (chipAddr),
    .payload  (payload)
  );

  frameSerializer uSerializer (
    .Clock    (Clock),
    .arstN    (arstN),
    .cmdReq   (cmdReq),
    .opcode   (opcode),
    .chipAddr (chipAddr),
    .payload  (payload),
    .cmdAck   (cmdAck),
    .CMD      (CMD)
  );

endmodule

`default_nettype wire

//--- dv/asicCfgTb.sv
/*
  Directed testbench for the tracker ASIC configuration sequencer.
  A decoder on CMD rebuilds every frame and the tests compare them with the board defaults.
  Frame length is timed from the start bit to the rise of the internal cmdAck.
  Runs the command list twice and expects the same 37-frame stream both times.
  Default parameters only: twelve chips and a 16-cycle gap.
*/
`default_nettype none
`timescale 1ns/100ps

module asicCfgTb;

  import asicCfgPkg::*;

  localparam int NumChips    = 12;
  localparam int GapCycles   = 16;
  localparam int RunFrames   = 1 + 3 * NumChips;               // 37
  localparam int FrameBudget = FrameMaxBits + 13 + GapCycles;  // Longest frame with its gap
  localparam int CycleLimit  = 3 * RunFrames * FrameBudget;    // About three full runs
  localparam int MaxFrames   = 128;

  logic Clock;
  logic arstN;
  logic Go;
  logic CMD;
  logic Done;

  // Frames as rebuilt by the decoder
  logic [1:0]     frStart [MaxFrames];
  logic [3:0]     frAddr  [MaxFrames];
  logic [3:0]     frOp    [MaxFrames];
  logic           frPar   [MaxFrames];
  settingPayloadT frPay   [MaxFrames];
  logic [1:0]     frTrail [MaxFrames];
  int             frLen   [MaxFrames];  // Bits on CMD before cmdAck rose
  int             frGap   [MaxFrames];  // Idle cycles before the frame
  int             frameCount = 0;

  // Decoder working state
  logic        inFrame = 1'b0;
  int          bitNum;
  int          expLen;
  int          idleRun = 0;
  logic [9:0]  hdr;                     // Start pair, address, opcode
  logic        par;
  logic [63:0] pay;
  logic [1:0]  trail;
  int          lineIdx  = 0;            // Frame the serializer is sending
  int          lineBits = 0;            // Cycles since its start bit
  logic        ackPrev  = 1'b0;

  int   doneCount = 0;
  int   doneFrame [4];                  // Frames seen when each Done pulse came
  logic donePrev  = 1'b0;
  logic doneLong  = 1'b0;

  int numTests   = 0;
  int numChecks  = 0;
  int numErrors  = 0;
  int cycleCount = 0;

  asicCfgTop dut (
    .Clock (Clock),
    .arstN (arstN),
    .Go    (Go),
    .CMD   (CMD),
    .Done  (Done)
  );

  always #2 Clock = ~Clock;

  // Hard stop for a hung run
  always @(posedge Clock) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  // Payload width by opcode, as the ASICs read it
  function automatic int payloadBits(input logic [3:0] op);
    case (op)
      OpConfig: return CfgBits;
      OpThrDac: return DacBits;
      default:  return MaskBits;
    endcase
  endfunction

  // Frame decoder, CMD is stable on the falling edge
  always @(negedge Clock) begin
    if (arstN) begin
      if (!inFrame) begin
        if (CMD) begin                  // Start bit after idle
          inFrame  = 1'b1;
          bitNum   = 1;
          hdr      = 10'b1;
          expLen   = FrameMaxBits;      // Until the opcode is known
          pay      = '0;
          trail    = '0;
          lineIdx  = frameCount;
          lineBits = 0;
        end else begin
          idleRun++;
        end
      end else begin
        bitNum++;
        if (bitNum <= 10) hdr = {hdr[8:0], CMD};
        else if (bitNum == 11) par = CMD;
        else if (bitNum <= expLen - 2) pay = {pay[62:0], CMD};
        else trail = {trail[0], CMD};
        if (bitNum == 10) expLen = 13 + payloadBits(hdr[3:0]);
        if (bitNum == expLen) begin
          if (frameCount < MaxFrames) begin
            frStart[frameCount] = hdr[9:8];
            frAddr[frameCount]  = hdr[7:4];
            frOp[frameCount]    = hdr[3:0];
            frPar[frameCount]   = par;
            frPay[frameCount]   = pay;
            frTrail[frameCount] = trail;
            frGap[frameCount]   = idleRun;
          end
          frameCount++;
          inFrame = 1'b0;
          idleRun = 0;
        end
      end
      // cmdAck rises on the cycle after the last bit of the frame
      if (dut.cmdAck && !ackPrev && lineIdx < MaxFrames) frLen[lineIdx] = lineBits;
      ackPrev = dut.cmdAck;
      lineBits++;
      if (Done) begin
        if (donePrev) doneLong = 1'b1;  // Pulse wider than one cycle
        else begin
          if (doneCount < 4) doneFrame[doneCount] = frameCount;
          doneCount++;
        end
      end
      donePrev = Done;
    end
  end

  task automatic checkPayload(input string what, input settingPayloadT got,
                              input settingPayloadT exp);
    numChecks++;
    if (got !== exp) begin
      numErrors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkField(input string what, input logic [3:0] got, input logic [3:0] exp);
    numChecks++;
    if (got !== exp) begin
      numErrors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    numChecks++;
    if (got !== exp) begin
      numErrors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input string what, input int got, input int exp);
    numChecks++;
    if (got != exp) begin
      numErrors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Board thresholds, chips 0 to 11
  function automatic logic [7:0] thrFor(input int chip);
    case (chip)
      2, 8:    return 8'd21;
      3, 6:    return 8'd20;
      5, 7:    return 8'd24;
      9, 10:   return 8'd23;
      default: return 8'd22;            // Chips 0, 1, 4 and 11
    endcase
  endfunction

  function automatic settingPayloadT expectedPayload(input logic [3:0] op, input int chip);
    settingPayloadT p;
    p = '0;
    case (op)
      OpConfig:   p.cfg.word = 19'b1010111001000111000;
      OpThrDac:   p.dac.thr = thrFor(chip);
      OpDataMask: p.mask = '1;
      default: begin
        p.mask = '1;
        if (chip == 0) p.mask[0] = 1'b0;           // Edge channels out of the trigger
        if (chip == 11) p.mask[63] = 1'b0;
      end
    endcase
    return p;
  endfunction

  // Frame idx of the stream against entry k of the command list
  task automatic checkFrame(input int idx, input int k);
    logic [3:0] op;
    int         chip;
    int         len;
    string      tag;
    if (k == 0) begin
      op   = OpConfig;
      chip = BroadcastAddr;
      len  = 32;
    end else begin
      chip = (k - 1) % NumChips;
      case ((k - 1) / NumChips)
        0:       op = OpThrDac;
        1:       op = OpDataMask;
        default: op = OpTrigMask;
      endcase
      len = (op == OpThrDac) ? 21 : 77;
    end
    tag = $sformatf("frame %0d", idx);
    checkBit({tag, " start zero"}, frStart[idx][0], StartBits[0]);
    checkField({tag, " address"}, frAddr[idx], 4'(chip));
    checkField({tag, " opcode"}, frOp[idx], op);
    checkBit({tag, " even parity"}, ^{frAddr[idx], frOp[idx], frPar[idx], frPay[idx]}, 1'b0);
    checkPayload({tag, " payload"}, frPay[idx], expectedPayload(op, chip));
    checkBit({tag, " trailer"}, |(frTrail[idx] ^ TrailBits), 1'b0);
    checkCount({tag, " length"}, frLen[idx], len);
  endtask

  // Waits for frames and Done pulses, gives up when the stream stalls
  task automatic waitProgress(input int frames, input int dones, output logic ok);
    int waited;
    int lastCount;
    waited    = 0;
    lastCount = frameCount;
    while ((frameCount < frames || doneCount < dones) && waited < 2 * FrameBudget) begin
      @(posedge Clock);
      waited++;
      if (frameCount != lastCount) begin
        waited    = 0;
        lastCount = frameCount;
      end
    end
    @(posedge Clock);                   // Decoder logs the closing cmdAck meanwhile
    ok = (frameCount >= frames) && (doneCount >= dones);
    if (frameCount < frames) begin
      numErrors++;
      $display("frame %0d never appeared on CMD", frames - 1);
    end else if (!ok) begin
      numErrors++;
      $display("Done did not pulse after frame %0d", frames - 1);
    end
  endtask

  task automatic pulseGo();
    @(posedge Clock);
    Go <= 1'b1;
    @(posedge Clock);
    Go <= 1'b0;
  endtask

  task automatic report(input string name, input int startErrors);
    numTests++;
    $display("test %-20s %s", name, (numErrors == startErrors) ? "ok" : "failed");
  endtask

  task automatic resetQuiet();
    int startErrors;
    startErrors = numErrors;
    repeat (20) begin
      @(negedge Clock);
      checkBit("CMD after reset", CMD, 1'b0);
      checkBit("Done after reset", Done, 1'b0);
    end
    report("reset quiet", startErrors);
  endtask

  task automatic configFrame();
    int   startErrors;
    logic ok;
    startErrors = numErrors;
    pulseGo();
    waitProgress(1, 0, ok);
    if (ok) checkFrame(0, 0);
    report("configure frame", startErrors);
  endtask

  // Runs over entries first to last of the command list
  task automatic frameRange(input string name, input int first, input int last);
    int   startErrors;
    logic ok;
    startErrors = numErrors;
    ok = 1'b1;
    for (int k = first; k <= last && ok; k++) begin
      waitProgress(k + 1, 0, ok);
      if (ok) checkFrame(k, k);
    end
    report(name, startErrors);
  endtask

  task automatic gapsAndDone();
    int   startErrors;
    logic ok;
    startErrors = numErrors;
    waitProgress(RunFrames, 1, ok);
    checkCount("frames before first Done", doneFrame[0], RunFrames);
    for (int k = 1; k < 2 * RunFrames; k++) begin
      if (k != RunFrames) checkBit($sformatf("gap before frame %0d", k),
                                   frGap[k] >= GapCycles, 1'b1);
      if (k == 1) begin                 // Second run, with a stray Go in its middle
        pulseGo();
        waitProgress(RunFrames + 3, 1, ok);
        pulseGo();
        waitProgress(2 * RunFrames, 2, ok);
        repeat (2 * FrameBudget) @(posedge Clock);  // Room for any stray frame
      end
    end
    checkCount("total frames", frameCount, 2 * RunFrames);
    checkCount("total Done pulses", doneCount, 2);
    checkCount("frames before second Done", doneFrame[1], 2 * RunFrames);
    checkBit("Done wider than one cycle", doneLong, 1'b0);
    for (int k = 0; k < RunFrames; k++) begin
      checkField($sformatf("rerun frame %0d address", k), frAddr[RunFrames + k], frAddr[k]);
      checkField($sformatf("rerun frame %0d opcode", k), frOp[RunFrames + k], frOp[k]);
      checkPayload($sformatf("rerun frame %0d payload", k), frPay[RunFrames + k], frPay[k]);
      checkCount($sformatf("rerun frame %0d length", k), frLen[RunFrames + k], frLen[k]);
    end
    report("gaps and completion", startErrors);
  endtask

  initial begin
    Clock = 1'b0;
    arstN = 1'b0;
    Go    = 1'b0;
    repeat (4) @(posedge Clock);
    arstN <= 1'b1;
    resetQuiet();
    configFrame();
    frameRange("threshold frames", 1, NumChips);
    frameRange("mask frames", NumChips + 1, RunFrames - 1);
    gapsAndDone();
    $display("tests %0d, checks %0d, errors %0d", numTests, numChecks, numErrors);
    if (numErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/asicCfgPkg.sv
design/cfgSequencer.sv
design/cfgSettingsTable.sv
design/frameSerializer.sv
design/asicCfgTop.sv
dv/asicCfgTb.sv

//--- Bender.yml
package:
  name: asic_cfg_sequencer
  description: "Power-up configuration sequencer for a twelve-ASIC tracker board"

sources:
  # Design, in compile order
  - design/asicCfgPkg.sv
  - design/cfgSequencer.sv
  - design/cfgSettingsTable.sv
  - design/frameSerializer.sv
  - design/asicCfgTop.sv

  # Testbench
  - target: simulation
    files:
      - dv/asicCfgTb.sv
